//--- Makefile
TOOL = verilator
FLAGS = --binary --timing -j 0
TOP = tbTop
FILELIST = tb.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  aluOp_t aluOp,
    output logic [dataWidth-1:0] result,
    output logic gt,
    output logic lt,
    output logic eq
);

    logic zeroCompare;
    logic signed [dataWidth-1:0] cmpA;
    logic signed [dataWidth-1:0] cmpB;

    // single-operand branches test a against zero
    assign zeroCompare = aluOp inside {aluCmpGez, aluCmpLtz, aluCmpGtz, aluCmpLez};

    assign cmpA = a;
    assign cmpB = zeroCompare ? '0 : b;

    assign gt = cmpA > cmpB;
    assign lt = cmpA < cmpB;
    assign eq = cmpA == cmpB;

    always_comb begin
        case (aluOp)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluMul: result = a * b;             // low word only
            aluSll: result = b << a[4:0];
            aluSrl: result = b >> a[4:0];
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluXor: result = a ^ b;
            aluNor: result = ~(a | b);
            aluSlt: result = {{(dataWidth-1){1'b0}}, lt};
            default: result = '0;               // nop and branch compares
        endcase
    end

endmodule

//--- logic/controller.sv
`timescale 1ns/1ps

module controller import mipsPkg::*; (
    input  logic [dataWidth-1:0] instruction,
    input  logic gt,
    input  logic lt,
    input  logic eq,
    output ctrl_t ctrl,
    output logic branchTaken
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];
    assign rt = instruction[20:16];

    function automatic ctrl_t rType(aluOp_t op);
        ctrl_t c;
        c = '0;
        c.regWrite = 1'b1;
        c.regDst = 1'b1;
        c.aluOp = op;
        return c;
    endfunction

    function automatic ctrl_t immType(aluOp_t op);
        ctrl_t c;
        c = '0;
        c.regWrite = 1'b1;
        c.aluSrc = 1'b1;
        c.aluOp = op;
        return c;
    endfunction

    function automatic ctrl_t loadType(memSize_t size);
        ctrl_t c;
        c = immType(aluAdd);    // add to get address
        c.memToReg = 1'b1;
        c.memRead = size;
        return c;
    endfunction

    function automatic ctrl_t storeType(memSize_t size);
        ctrl_t c;
        c = '0;
        c.aluSrc = 1'b1;
        c.aluOp = aluAdd;
        c.memWrite = size;
        return c;
    endfunction

    ////////////////////
    // main decode
    always_comb begin
        ctrl = '0;              // unknown encodings retire as no-ops
        case (opcode)
            opR: begin
                case (funct)
                    fnSll: begin
                        ctrl = rType(aluSll);
                        ctrl.shift = 1'b1;
                    end
                    fnSrl: begin
                        ctrl = rType(aluSrl);
                        ctrl.shift = 1'b1;
                    end
                    fnJr: ctrl.jr = 1'b1;
                    fnAdd: ctrl = rType(aluAdd);
                    fnSub: ctrl = rType(aluSub);
                    fnAnd: ctrl = rType(aluAnd);
                    fnOr: ctrl = rType(aluOr);
                    fnXor: ctrl = rType(aluXor);
                    fnNor: ctrl = rType(aluNor);
                    fnSlt: ctrl = rType(aluSlt);
                    default: ;
                endcase
            end
            opMul: if (funct == fnMul) ctrl = rType(aluMul);
            opLw: ctrl = loadType(memWord);
            opLh: ctrl = loadType(memHalf);
            opLb: ctrl = loadType(memByte);
            opSw: ctrl = storeType(memWord);
            opSh: ctrl = storeType(memHalf);
            opSb: ctrl = storeType(memByte);
            opAddi: ctrl = immType(aluAdd);
            opAndi: ctrl = immType(aluAnd);
            opOri: ctrl = immType(aluOr);
            opXori: ctrl = immType(aluXor);
            opSlti: ctrl = immType(aluSlt);
            opBeq: ctrl.aluOp = aluCmpEq;
            opBne: ctrl.aluOp = aluCmpNe;
            opRegImm: begin
                if (rt == rtBgez) ctrl.aluOp = aluCmpGez;
                else if (rt == rtBltz) ctrl.aluOp = aluCmpLtz;
            end
            opBgtz: ctrl.aluOp = aluCmpGtz;
            opBlez: ctrl.aluOp = aluCmpLez;
            opJ: ctrl.jump = 1'b1;
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.jal = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////
    // branch resolution from the alu flags
    always_comb begin
        branchTaken = 1'b0;
        case (opcode)
            opBeq: branchTaken = eq;
            opBne: branchTaken = !eq;
            opRegImm: begin
                if (rt == rtBgez) branchTaken = gt | eq;
                else if (rt == rtBltz) branchTaken = lt;
            end
            opBgtz: branchTaken = gt;
            opBlez: branchTaken = lt | eq;
            default: ;
        endcase
    end

endmodule

//--- logic/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [dataWidth-1:0] addr,
    input  logic [dataWidth-1:0] writeData,
    input  memSize_t readSize,
    input  memSize_t writeSize,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0] mem [dmemDepth];
    logic [dmemAddrWidth-1:0] wordIndex;
    logic [1:0] laneSel;
    logic [dataWidth-1:0] word;
    logic [dataWidth-1:0] laneData;
    logic [3:0] laneMask;
    logic [15:0] halfLane;
    logic [7:0] byteLane;

    initial begin
        for (int i = 0; i < dmemDepth; i++) begin
            mem[i] = '0;
        end
    end

    assign wordIndex = addr[dmemAddrWidth+1:2];     // wraps with the memory size
    assign laneSel = addr[1:0];
    assign word = mem[wordIndex];

    ////////////////////
    // store lanes, little endian
    always_comb begin
        case (writeSize)
            memWord: begin
                laneMask = 4'b1111;
                laneData = writeData;
            end
            memHalf: begin
                laneMask = laneSel[1] ? 4'b1100 : 4'b0011;
                laneData = {2{writeData[15:0]}};
            end
            memByte: begin
                laneMask = 4'b0001 << laneSel;
                laneData = {4{writeData[7:0]}};
            end
            default: begin
                laneMask = 4'b0000;
                laneData = writeData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < 4; i++) begin
                if (laneMask[i]) mem[wordIndex][8*i +: 8] <= laneData[8*i +: 8];
            end
        end
    end

    // loads sign extend
    assign halfLane = laneSel[1] ? word[31:16] : word[15:0];
    assign byteLane = word[{laneSel, 3'b000} +: 8];

    always_comb begin
        case (readSize)
            memWord: readData = word;
            memHalf: readData = {{(dataWidth-16){halfLane[15]}}, halfLane};
            memByte: readData = {{(dataWidth-8){byteLane[7]}}, byteLane};
            default: readData = '0;
        endcase
    end

endmodule

//--- logic/instructionMemory.sv
`timescale 1ns/1ps

module instructionMemory import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic loadEn,
    input  logic [imemAddrWidth-1:0] loadAddr,
    input  logic [dataWidth-1:0] loadData,
    input  logic [dataWidth-1:0] pc,
    output logic [dataWidth-1:0] instruction
);

    logic [dataWidth-1:0] mem [imemDepth];
    logic [imemAddrWidth-1:0] fetchIndex;

    // unloaded words decode as sll $0, $0, 0
    initial begin
        for (int i = 0; i < imemDepth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset && loadEn) begin      // program load only while held in reset
            mem[loadAddr] <= loadData;
        end
    end

    assign fetchIndex = pc[imemAddrWidth+1:2];
    assign instruction = mem[fetchIndex];

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic loadEn,
    input  logic [imemAddrWidth-1:0] loadAddr,
    input  logic [dataWidth-1:0] loadData,
    output logic retireValid,
    output retire_t retire
);

    logic [dataWidth-1:0] instruction, pc, pcPlus4;
    logic [dataWidth-1:0] rsValue, rtValue;
    logic [dataWidth-1:0] immExt, aluA, aluB, aluResult;
    logic [dataWidth-1:0] memReadData, writeData;
    logic [regAddrWidth-1:0] writeAddr;
    logic [5:0] opcode;
    logic zeroExtend;
    logic gt, lt, eq, branchTaken, regWe, memWe;
    ctrl_t ctrl;

    assign opcode = instruction[31:26];

    instructionMemory imem (.clk, .reset, .loadEn, .loadAddr, .loadData, .pc, .instruction);

    controller ctrlUnit (.instruction, .gt, .lt, .eq, .ctrl, .branchTaken);

    pcUnit pcu (.clk, .reset, .instruction, .rsValue, .branchTaken, .jump(ctrl.jump),
        .jr(ctrl.jr), .pc, .pcPlus4);

    registerFile regs (.clk, .reset, .readAddrA(instruction[25:21]),
        .readAddrB(instruction[20:16]), .readDataA(rsValue), .readDataB(rtValue),
        .writeEn(regWe), .writeAddr, .writeData);

    ////////////////////
    // operand select
    assign zeroExtend = opcode inside {opAndi, opOri, opXori};     // logical immediates
    assign immExt = zeroExtend ? {{(dataWidth-16){1'b0}}, instruction[15:0]}
                               : {{(dataWidth-16){instruction[15]}}, instruction[15:0]};
    assign aluA = ctrl.shift ? {{(dataWidth-5){1'b0}}, instruction[10:6]} : rsValue;
    assign aluB = ctrl.aluSrc ? immExt : rtValue;

    alu aluUnit (.a(aluA), .b(aluB), .aluOp(ctrl.aluOp), .result(aluResult), .gt, .lt, .eq);

    dataMemory dmem (.clk, .reset, .addr(aluResult), .writeData(rtValue),
        .readSize(ctrl.memRead), .writeSize(ctrl.memWrite), .readData(memReadData));

    // write back
    assign writeAddr = ctrl.jal ? linkReg : (ctrl.regDst ? instruction[15:11] : instruction[20:16]);
    assign writeData = ctrl.jal ? pcPlus4 : (ctrl.memToReg ? memReadData : aluResult);
    assign regWe = ctrl.regWrite && !reset;
    assign memWe = (ctrl.memWrite != memNone) && !reset;

    ////////////////////
    // retire trace, one record per cycle
    assign retireValid = !reset;

    always_comb begin
        retire.pc = pc;
        retire.regWe = regWe;
        retire.regAddr = writeAddr;
        retire.regData = writeData;
        retire.memWe = memWe;
        retire.memSize = ctrl.memWrite;
        retire.memAddr = aluResult;
        retire.memData = rtValue;       // raw rt, lanes chosen by memSize
    end

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int imemAddrWidth = $clog2(imemDepth);
    localparam int dmemAddrWidth = $clog2(dmemDepth);
    localparam int regAddrWidth = 5;
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;  // jal target register

    //////////////////// opcodes
    localparam logic [5:0] opR = 6'b000000;
    localparam logic [5:0] opMul = 6'b011100;   // special2
    localparam logic [5:0] opLw = 6'b100011;
    localparam logic [5:0] opLb = 6'b100000;
    localparam logic [5:0] opLh = 6'b100001;
    localparam logic [5:0] opSw = 6'b101011;
    localparam logic [5:0] opSb = 6'b101000;
    localparam logic [5:0] opSh = 6'b101001;
    localparam logic [5:0] opAddi = 6'b001000;
    localparam logic [5:0] opAndi = 6'b001100;
    localparam logic [5:0] opOri = 6'b001101;
    localparam logic [5:0] opXori = 6'b001110;
    localparam logic [5:0] opSlti = 6'b001010;
    localparam logic [5:0] opBeq = 6'b000100;
    localparam logic [5:0] opBne = 6'b000101;
    localparam logic [5:0] opRegImm = 6'b000001;  // bgez, bltz
    localparam logic [5:0] opBgtz = 6'b000111;
    localparam logic [5:0] opBlez = 6'b000110;
    localparam logic [5:0] opJ = 6'b000010;
    localparam logic [5:0] opJal = 6'b000011;

    //////////////////// function field
    localparam logic [5:0] fnSll = 6'b000000;
    localparam logic [5:0] fnSrl = 6'b000010;
    localparam logic [5:0] fnJr = 6'b001000;
    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr = 6'b100101;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnNor = 6'b100111;
    localparam logic [5:0] fnSlt = 6'b101010;
    localparam logic [5:0] fnMul = 6'b000010;   // under opMul only

    // rt field selects the regimm branch
    localparam logic [4:0] rtBltz = 5'b00000;
    localparam logic [4:0] rtBgez = 5'b00001;

    typedef enum logic [4:0] {
        aluNop    = 5'b00000,
        aluAdd    = 5'b00001,
        aluSub    = 5'b00010,
        aluMul    = 5'b00011,
        aluSll    = 5'b00100,
        aluSrl    = 5'b00101,
        aluAnd    = 5'b00110,
        aluOr     = 5'b00111,
        aluXor    = 5'b01000,
        aluCmpGez = 5'b01011,
        aluCmpEq  = 5'b01100,
        aluNor    = 5'b01101,
        aluSlt    = 5'b01110,
        aluCmpNe  = 5'b01111,
        aluCmpGtz = 5'b10000,
        aluCmpLez = 5'b10001,
        aluCmpLtz = 5'b10010
    } aluOp_t;

    typedef enum logic [1:0] {
        memNone = 2'b00,
        memWord = 2'b01,
        memHalf = 2'b10,
        memByte = 2'b11
    } memSize_t;

    typedef struct packed {
        logic regWrite;
        logic aluSrc;       // b is the immediate
        logic regDst;       // rd instead of rt
        logic memToReg;
        logic jump;
        logic jr;
        logic jal;
        logic shift;        // a is shamt
        aluOp_t aluOp;
        memSize_t memRead;
        memSize_t memWrite;
    } ctrl_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic regWe;
        logic [regAddrWidth-1:0] regAddr;
        logic [dataWidth-1:0] regData;
        logic memWe;
        memSize_t memSize;
        logic [dataWidth-1:0] memAddr;
        logic [dataWidth-1:0] memData;
    } retire_t;

endpackage

//--- logic/pcUnit.sv
`timescale 1ns/1ps

module pcUnit import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [dataWidth-1:0] instruction,
    input  logic [dataWidth-1:0] rsValue,
    input  logic branchTaken,
    input  logic jump,
    input  logic jr,
    output logic [dataWidth-1:0] pc,
    output logic [dataWidth-1:0] pcPlus4
);

    logic [dataWidth-1:0] branchOffset;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] jumpTarget;
    logic [dataWidth-1:0] nextPc;

    assign pcPlus4 = pc + 32'd4;
    assign branchOffset = {{(dataWidth-18){instruction[15]}}, instruction[15:0], 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;
    assign jumpTarget = {pcPlus4[31:28], instruction[25:0], 2'b00};   // region of pc+4

    always_comb begin
        if (jr) nextPc = rsValue;
        else if (jump) nextPc = jumpTarget;
        else if (branchTaken) nextPc = branchTarget;
        else nextPc = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= '0;
        else pc <= nextPc;
    end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    output logic [dataWidth-1:0] readDataA,
    output logic [dataWidth-1:0] readDataB,
    input  logic writeEn,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0] writeData
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    initial begin
        for (int i = 0; i < 2**regAddrWidth; i++) begin
            regs[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn && !reset && writeAddr != '0) begin    // $zero is hardwired
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- sim/tbChecker.sv
`timescale 1ns/1ps

module tbChecker import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic loadEn,
    input  logic [imemAddrWidth-1:0] loadAddr,
    input  logic [dataWidth-1:0] loadData,
    input  logic retireValid,
    input  retire_t retire,
    output int passCount,
    output int failCount,
    output int doneCount
);

    logic [dataWidth-1:0] modelRegs [32];
    logic [7:0] modelBytes [4*dmemDepth];       // byte addressed, little endian
    logic [dataWidth-1:0] imemModel [imemDepth];
    logic [dataWidth-1:0] modelPc;
    logic testDone;
    int testErrors;

    initial begin
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        for (int i = 0; i < 4*dmemDepth; i++) modelBytes[i] = '0;
        for (int i = 0; i < imemDepth; i++) imemModel[i] = '0;
        modelPc = '0;
        testDone = 1'b0;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        doneCount = 0;
    end

    // mirror of the program load
    always @(posedge clk) begin
        if (reset && loadEn) imemModel[loadAddr] <= loadData;
    end

    function automatic logic [7:0] readByte(logic [31:0] addr);
        return modelBytes[addr[dmemAddrWidth+1:0]];
    endfunction

    function automatic void writeByte(logic [31:0] addr, logic [7:0] data);
        modelBytes[addr[dmemAddrWidth+1:0]] = data;
    endfunction

    ////////////////////
    // reference model, one instruction per call
    function automatic retire_t stepModel(output logic [31:0] nextPc);
        logic [31:0] instr, pc4, rsv, rtv, simm, zimm, addr, val;
        logic [5:0] op, fn;
        logic [4:0] rs, rt, rd, sh, dst;
        logic wr;
        retire_t r;
        instr = imemModel[modelPc[imemAddrWidth+1:2]];
        op = instr[31:26];
        rs = instr[25:21];
        rt = instr[20:16];
        rd = instr[15:11];
        sh = instr[10:6];
        fn = instr[5:0];
        rsv = modelRegs[rs];
        rtv = modelRegs[rt];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        pc4 = modelPc + 32'd4;
        addr = rsv + simm;
        r = '0;
        r.pc = modelPc;
        nextPc = pc4;
        wr = 1'b0;
        dst = rt;
        val = '0;
        case (op)
            opR: begin
                wr = 1'b1;
                dst = rd;
                case (fn)
                    fnSll: val = rtv << sh;
                    fnSrl: val = rtv >> sh;
                    fnAdd: val = rsv + rtv;
                    fnSub: val = rsv - rtv;
                    fnAnd: val = rsv & rtv;
                    fnOr: val = rsv | rtv;
                    fnXor: val = rsv ^ rtv;
                    fnNor: val = ~(rsv | rtv);
                    fnSlt: val = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
                    fnJr: begin
                        wr = 1'b0;
                        nextPc = rsv;
                    end
                    default: wr = 1'b0;
                endcase
            end
            opMul: begin
                wr = (fn == fnMul);
                dst = rd;
                val = rsv * rtv;
            end
            opAddi: {wr, val} = {1'b1, rsv + simm};
            opAndi: {wr, val} = {1'b1, rsv & zimm};
            opOri: {wr, val} = {1'b1, rsv | zimm};
            opXori: {wr, val} = {1'b1, rsv ^ zimm};
            opSlti: {wr, val} = {1'b1, ($signed(rsv) < $signed(simm)) ? 32'd1 : 32'd0};
            opLw: {wr, val} = {1'b1, readByte(addr + 3), readByte(addr + 2),
                readByte(addr + 1), readByte(addr)};
            opLh: begin
                wr = 1'b1;
                val = {16'h0000, readByte(addr + 1), readByte(addr)};
                val[31:16] = {16{val[15]}};     // sign extend
            end
            opLb: begin
                wr = 1'b1;
                val = {24'h000000, readByte(addr)};
                val[31:8] = {24{val[7]}};
            end
            opSw, opSh, opSb: begin
                r.memWe = 1'b1;
                r.memAddr = addr;
                r.memData = rtv;
                r.memSize = (op == opSw) ? memWord : ((op == opSh) ? memHalf : memByte);
                writeByte(addr, rtv[7:0]);
                if (op != opSb) writeByte(addr + 1, rtv[15:8]);
                if (op == opSw) begin
                    writeByte(addr + 2, rtv[23:16]);
                    writeByte(addr + 3, rtv[31:24]);
                end
            end
            opBeq: if (rsv == rtv) nextPc = pc4 + (simm << 2);
            opBne: if (rsv != rtv) nextPc = pc4 + (simm << 2);
            opRegImm: begin
                if (rt == 5'd1 && !rsv[31]) nextPc = pc4 + (simm << 2);
                if (rt == 5'd0 && rsv[31]) nextPc = pc4 + (simm << 2);
            end
            opBgtz: if (!rsv[31] && rsv != 0) nextPc = pc4 + (simm << 2);
            opBlez: if (rsv[31] || rsv == 0) nextPc = pc4 + (simm << 2);
            opJ: nextPc = {pc4[31:28], instr[25:0], 2'b00};
            opJal: begin
                nextPc = {pc4[31:28], instr[25:0], 2'b00};
                {wr, val} = {1'b1, pc4};
                dst = 5'd31;
            end
            default: ;      // unknown opcode retires as no-op
        endcase
        if (wr && dst != 0) modelRegs[dst] = val;
        r.regWe = wr;
        r.regAddr = dst;
        r.regData = val;
        return r;
    endfunction

    task automatic checkField(string name, logic [31:0] expV, logic [31:0] actV);
        if (expV !== actV) begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expV, actV);
            testErrors++;
        end
    endtask

    ////////////////////
    // compare on the falling edge, where the trace is settled
    always @(negedge clk) begin
        retire_t exp;
        logic [31:0] nextPc;
        if (reset) begin
            checkField("retireValid in reset", 32'd0, {31'd0, retireValid});
            checkField("regWe in reset", 32'd0, {31'd0, retire.regWe});
            checkField("memWe in reset", 32'd0, {31'd0, retire.memWe});
            modelPc = '0;
            testDone = 1'b0;
        end else begin
            checkField("retireValid", 32'd1, {31'd0, retireValid});
            exp = stepModel(nextPc);
            checkField("pc", exp.pc, retire.pc);
            checkField("regWe", {31'd0, exp.regWe}, {31'd0, retire.regWe});
            if (exp.regWe) begin
                checkField("regAddr", {27'd0, exp.regAddr}, {27'd0, retire.regAddr});
                checkField("regData", exp.regData, retire.regData);
            end
            checkField("memWe", {31'd0, exp.memWe}, {31'd0, retire.memWe});
            if (exp.memWe) begin
                checkField("memSize", {30'd0, exp.memSize}, {30'd0, retire.memSize});
                checkField("memAddr", exp.memAddr, retire.memAddr);
                checkField("memData", exp.memData, retire.memData);
            end
            if (!testDone && nextPc == exp.pc) begin       // final self-jump reached
                testDone = 1'b1;
                $display("test %0d %s with %0d mismatches", doneCount,
                    (testErrors == 0) ? "passed" : "failed", testErrors);
                if (testErrors == 0) passCount++;
                else failCount++;
                testErrors = 0;
                doneCount++;
            end
            modelPc = nextPc;
        end
    end

endmodule

//--- sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- sim/tbTop.sv
`timescale 1ns/1ps

module tbTop import mipsPkg::*; ;

    localparam int numTests = 5;
    localparam int maxWords = 64;

    logic clk, clkReset, holdReset, coreReset, loadEn, retireValid, programsReady;
    logic [imemAddrWidth-1:0] loadAddr;
    logic [dataWidth-1:0] loadData;
    retire_t retire;
    int passCount, failCount, doneCount, cycleLimit;
    logic [31:0] progs [numTests][maxWords];
    int progLen [numTests];

    tbClock clkGen (.clk, .reset(clkReset));

    assign coreReset = clkReset | holdReset;

    mipsCore dut (.clk, .reset(coreReset), .loadEn, .loadAddr, .loadData, .retireValid,
        .retire);

    tbChecker traceCheck (.clk, .reset(coreReset), .loadEn, .loadAddr, .loadData,
        .retireValid, .retire, .passCount, .failCount, .doneCount);

    function automatic logic [31:0] rInstr(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
            logic [4:0] rd, logic [4:0] sh, logic [5:0] fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iInstr(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jInstr(logic [5:0] op, int index);
        return {op, 26'(index)};
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(1 + $urandom % 8);
    endfunction

    task automatic emit(int t, logic [31:0] word);
        progs[t][progLen[t]] = word;
        progLen[t]++;
    endtask

    task automatic emitSelfJump(int t);
        emit(t, jInstr(opJ, progLen[t]));
    endtask

    ////////////////////
    // program builders
    task automatic buildArith(int t);
        logic [5:0] fns [7];
        fns = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt};
        for (int r = 1; r <= 8; r++) emit(t, iInstr(opAddi, 0, 5'(r), 16'($urandom)));
        for (int i = 0; i < 7; i++) begin
            emit(t, rInstr(opR, randReg(), randReg(), 5'(9 + i), 0, fns[i]));
        end
        emit(t, rInstr(opMul, randReg(), randReg(), 16, 0, fnMul));
        emit(t, rInstr(opR, 0, randReg(), 17, 5'($urandom), fnSll));
        emit(t, rInstr(opR, 0, randReg(), 18, 5'($urandom), fnSrl));
        emit(t, iInstr(opAddi, randReg(), 19, 16'($urandom)));
        emit(t, iInstr(opAndi, randReg(), 20, 16'($urandom)));
        emit(t, iInstr(opOri, randReg(), 21, 16'($urandom)));
        emit(t, iInstr(opXori, randReg(), 22, 16'($urandom)));
        emit(t, iInstr(opSlti, randReg(), 23, 16'($urandom)));
        emit(t, rInstr(opR, 1, 2, 0, 0, fnAdd));     // $zero stays zero
        emit(t, iInstr(opAddi, 1, 0, 16'($urandom)));
        emit(t, rInstr(opR, 0, 1, 24, 0, fnAdd));
        emitSelfJump(t);
    endtask

    task automatic buildMemory(int t);
        int w;
        for (int r = 1; r <= 3; r++) emit(t, iInstr(opAddi, 0, 5'(r), 16'($urandom)));
        for (int k = 0; k < 4; k++) begin
            w = ($urandom % dmemDepth) * 4;
            emit(t, iInstr(opSw, 0, 1, 16'(w)));
            emit(t, iInstr(opSh, 0, 2, 16'(w + 2 * ($urandom % 2))));
            emit(t, iInstr(opSb, 0, 3, 16'(w + $urandom % 4)));
            emit(t, iInstr(opLw, 0, 10, 16'(w)));
            emit(t, iInstr(opLh, 0, 11, 16'(w + 2 * ($urandom % 2))));
            emit(t, iInstr(opLb, 0, 12, 16'(w + $urandom % 4)));
        end
        emitSelfJump(t);
    endtask

    task automatic buildBranch(int t);
        emit(t, iInstr(opAddi, 0, 1, -16'(1 + $urandom % 1000)));  // negative
        emit(t, iInstr(opAddi, 0, 2, 16'd0));
        emit(t, iInstr(opAddi, 0, 3, 16'(1 + $urandom % 1000)));   // positive
        for (int r = 1; r <= 3; r++) begin
            emit(t, iInstr(opBeq, 5'(r), 2, 16'd1));
            emit(t, iInstr(opAddi, 20, 20, 16'd1));
            emit(t, iInstr(opBeq, 5'(r), 5'(r), 16'd1));
            emit(t, iInstr(opAddi, 20, 20, 16'd1));
            emit(t, iInstr(opBne, 5'(r), 2, 16'd1));
            emit(t, iInstr(opAddi, 20, 20, 16'd1));
            emit(t, iInstr(opRegImm, 5'(r), rtBgez, 16'd1));
            emit(t, iInstr(opAddi, 20, 20, 16'd1));
            emit(t, iInstr(opRegImm, 5'(r), rtBltz, 16'd1));
            emit(t, iInstr(opAddi, 20, 20, 16'd1));
            emit(t, iInstr(opBgtz, 5'(r), 0, 16'd1));
            emit(t, iInstr(opAddi, 20, 20, 16'd1));
            emit(t, iInstr(opBlez, 5'(r), 0, 16'd1));
            emit(t, iInstr(opAddi, 20, 20, 16'd1));
        end
        // backward branch, loops twice
        emit(t, iInstr(opAddi, 0, 21, 16'd2));
        emit(t, iInstr(opAddi, 21, 21, 16'hffff));
        emit(t, iInstr(opBgtz, 21, 0, 16'hfffe));
        emitSelfJump(t);
    endtask

    task automatic buildJump(int t);
        emit(t, iInstr(opAddi, 0, 5, 16'($urandom)));
        emit(t, jInstr(opJal, 5));
        emit(t, jInstr(opJ, 8));                    // return point of jr
        emit(t, iInstr(opAddi, 0, 6, 16'd1));
        emit(t, iInstr(opAddi, 0, 6, 16'd2));
        emit(t, iInstr(opAddi, 5, 7, 16'd1));       // subroutine
        emit(t, rInstr(opR, 31, 0, 0, 0, fnJr));
        emit(t, iInstr(opAddi, 0, 6, 16'd3));
        emitSelfJump(t);
    endtask

    task automatic buildUnknown(int t);
        emit(t, {6'b111111, 26'($urandom)});
        emit(t, {6'b010011, 26'($urandom)});
        emit(t, rInstr(opR, 1, 2, 3, 0, 6'b111111));
        emit(t, rInstr(opMul, 1, 2, 3, 0, 6'b000000));
        emit(t, iInstr(opRegImm, 1, 5'b00011, 16'd1));
        emitSelfJump(t);
    endtask

    task automatic loadProgram(int t);
        @(posedge clk);
        holdReset <= 1'b1;
        for (int i = 0; i < progLen[t]; i++) begin
            @(posedge clk);
            loadEn <= 1'b1;
            loadAddr <= imemAddrWidth'(i);
            loadData <= progs[t][i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        @(posedge clk);
        holdReset <= 1'b0;
    endtask

    ////////////////////
    initial begin
        holdReset = 1'b1;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        programsReady = 1'b0;
        cycleLimit = 0;
        void'($urandom(32'h6f98));
        for (int t = 0; t < numTests; t++) progLen[t] = 0;
        buildArith(0);
        buildMemory(1);
        buildBranch(2);
        buildJump(3);
        buildUnknown(4);
        for (int t = 0; t < numTests; t++) cycleLimit += progLen[t] * 20;
        programsReady = 1'b1;
        for (int t = 0; t < numTests; t++) begin
            loadProgram(t);
            wait (doneCount == t + 1);
        end
        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && passCount == numTests) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (programsReady);
        repeat (cycleLimit) @(posedge clk);
        $display("run timed out after %0d cycles before all programs finished", cycleLimit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb.f
logic/mipsPkg.sv
logic/controller.sv
logic/alu.sv
logic/registerFile.sv
logic/dataMemory.sv
logic/instructionMemory.sv
logic/pcUnit.sv
logic/mipsCore.sv
sim/tbClock.sv
sim/tbChecker.sv
sim/tbTop.sv
